// File: common/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

    localparam int DATA_WIDTH  = 16;
    localparam int ADDR_WIDTH  = 16;
    localparam int TOKEN_WIDTH = 7;

    // Q8.8 signed word
    typedef logic signed [DATA_WIDTH-1:0] fixed_t;

    // Read request to the weight memory
    typedef struct packed
    {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] address;
    } mem_req_t;

    // Word returned by the weight memory
    typedef struct packed
    {
        logic   valid;
        fixed_t data;
    } mem_rsp_t;

    // One product term, weight times operand
    typedef struct packed
    {
        logic   valid;
        logic   first;   // Restarts the accumulator
        logic   last;    // Closes the neuron sum
        fixed_t weight;
        fixed_t operand;
    } mac_term_t;

    // Finished neuron sum
    typedef struct packed
    {
        logic   valid;
        fixed_t sum;
    } mac_result_t;

endpackage

`default_nettype wire

// File: design/weight_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module weight_fetch (
    input  wire logic         clk,
    input  wire logic         reset,
    input  rnn_pkg::mem_req_t fetch_req,
    output rnn_pkg::mem_rsp_t fetch_rsp,
    output rnn_pkg::mem_req_t mem_req,
    input  rnn_pkg::mem_rsp_t mem_rsp
);

    logic pending;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_req.valid   <= 1'b0;
            fetch_rsp.valid <= 1'b0;
            pending         <= 1'b0;
        end
        else
        begin
            mem_req.valid   <= fetch_req.valid;
            fetch_rsp.valid <= mem_rsp.valid;
            if (fetch_req.valid)
                pending <= 1'b1;
            else if (mem_rsp.valid)
                pending <= 1'b0;   // Read closed by the memory
        end
        mem_req.address <= fetch_req.address;
        fetch_rsp.data  <= mem_rsp.data;
    end

    no_orphan_response: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.valid |-> pending);

endmodule

`default_nettype wire

// File: design/neuron_mac.sv
`timescale 1ns/1ps
`default_nettype none

module neuron_mac #(
    parameter int FRAC_BITS = 8
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  rnn_pkg::mac_term_t   mac_term,
    output rnn_pkg::mac_result_t mac_result
);

    typedef logic signed [2*rnn_pkg::DATA_WIDTH-1:0] product_t;

    // Stage one, raw product
    logic            s1_valid;
    logic            s1_first;
    logic            s1_last;
    product_t        s1_product;

    // Stage two, accumulator
    logic            result_valid;
    rnn_pkg::fixed_t acc;
    rnn_pkg::fixed_t scaled;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid     <= 1'b0;
            s1_first     <= 1'b0;
            s1_last      <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            s1_valid     <= mac_term.valid;
            s1_first     <= mac_term.first;
            s1_last      <= mac_term.last;
            result_valid <= s1_valid && s1_last;
        end
        s1_product <= product_t'(mac_term.weight) * product_t'(mac_term.operand);
        if (s1_valid)
            acc <= (s1_first ? '0 : acc) + scaled;  // Wraps modulo 2^16
    end

    // Back to Q8.8, upper bits dropped
    assign scaled = rnn_pkg::fixed_t'(s1_product >>> FRAC_BITS);

    assign mac_result = '{valid: result_valid, sum: acc};

endmodule

`default_nettype wire

// File: design/hidden_state_bank.sv
`timescale 1ns/1ps
`default_nettype none

module hidden_state_bank #(
    parameter int EMBEDDING_SIZE = 4,
    parameter int LINEAR_SIZE    = 8
) (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic                              emb_write,
    input  wire logic [$clog2(EMBEDDING_SIZE)-1:0] emb_index,
    input  rnn_pkg::fixed_t                        emb_data,
    input  wire logic                              neuron_write,
    input  wire logic [$clog2(LINEAR_SIZE)-1:0]    neuron_index,
    input  rnn_pkg::fixed_t                        neuron_sum,
    input  wire logic                              commit,
    input  wire logic [$clog2(LINEAR_SIZE)-1:0]    hidden_read_index,
    input  wire logic [$clog2(EMBEDDING_SIZE)-1:0] emb_read_index,
    input  wire logic [$clog2(LINEAR_SIZE)-1:0]    hidden_index,
    output rnn_pkg::fixed_t                        hidden_operand,
    output rnn_pkg::fixed_t                        emb_operand,
    output rnn_pkg::fixed_t                        hidden_value
);

    rnn_pkg::fixed_t emb_q      [EMBEDDING_SIZE];
    rnn_pkg::fixed_t new_layer  [LINEAR_SIZE];
    rnn_pkg::fixed_t prev_layer [LINEAR_SIZE];  // Committed state of the last step

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < EMBEDDING_SIZE; i++)
                emb_q[i] <= '0;
            for (int i = 0; i < LINEAR_SIZE; i++)
            begin
                new_layer[i]  <= '0;
                prev_layer[i] <= '0;
            end
        end
        else
        begin
            if (emb_write)
                emb_q[emb_index] <= emb_data;
            if (neuron_write)
                new_layer[neuron_index] <= neuron_sum;
            if (commit)
                prev_layer <= new_layer;
        end
    end

    assign hidden_operand = prev_layer[hidden_read_index];
    assign emb_operand    = emb_q[emb_read_index];
    assign hidden_value   = prev_layer[hidden_index];

    // A write in the commit cycle would be missing from the committed layer
    no_write_on_commit: assert property (@(posedge clk) disable iff (reset)
        commit |-> !neuron_write && !emb_write);

endmodule

`default_nettype wire

// File: design/step_sequencer/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer #(
    parameter int VOCAB_SIZE     = 76,
    parameter int EMBEDDING_SIZE = 4,
    parameter int LINEAR_SIZE    = 8,
    parameter int FRAC_BITS      = 8
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                execute,
    input  wire logic [rnn_pkg::TOKEN_WIDTH-1:0]     token,
    output rnn_pkg::mem_req_t                        fetch_req,
    input  rnn_pkg::mem_rsp_t                        fetch_rsp,
    output rnn_pkg::mac_term_t                       mac_term,
    input  rnn_pkg::mac_result_t                     mac_result,
    output logic                                     emb_write,
    output logic [$clog2(EMBEDDING_SIZE)-1:0]        emb_index,
    output logic                                     neuron_write,
    output logic [$clog2(LINEAR_SIZE)-1:0]           neuron_index,
    output rnn_pkg::fixed_t                          neuron_sum,
    output logic                                     commit,
    output logic [$clog2(LINEAR_SIZE)-1:0]           hidden_read_index,
    output logic [$clog2(EMBEDDING_SIZE)-1:0]        emb_read_index,
    input  rnn_pkg::fixed_t                          hidden_operand,
    input  rnn_pkg::fixed_t                          emb_operand,
    output logic                                     done
);

    localparam int AW = rnn_pkg::ADDR_WIDTH;
    localparam int EW = $clog2(EMBEDDING_SIZE);
    localparam int LW = $clog2(LINEAR_SIZE);

    localparam logic [AW-1:0] E_STEP    = AW'(EMBEDDING_SIZE);
    localparam logic [AW-1:0] L_STEP    = AW'(LINEAR_SIZE);
    localparam logic [AW-1:0] IH_W_BASE = AW'(VOCAB_SIZE * EMBEDDING_SIZE);
    localparam logic [AW-1:0] HH_W_BASE = IH_W_BASE + AW'(LINEAR_SIZE * EMBEDDING_SIZE);
    localparam logic [AW-1:0] IH_B_BASE = HH_W_BASE + AW'(LINEAR_SIZE * LINEAR_SIZE);
    localparam logic [AW-1:0] HH_B_BASE = IH_B_BASE + L_STEP;

    localparam logic [EW-1:0] EMB_LAST = EW'(EMBEDDING_SIZE - 1);
    localparam logic [LW-1:0] HID_LAST = LW'(LINEAR_SIZE - 1);

    localparam rnn_pkg::fixed_t FIXED_ONE = rnn_pkg::fixed_t'(1 << FRAC_BITS);

    typedef enum logic [2:0]
    {
        IDLE,
        EMB,       // Embedding words
        HH_W,      // Hidden-to-hidden weights
        HH_B,
        IH_W,      // Input-to-hidden weights
        IH_B,
        SUM_WAIT,  // Last term still in the MAC
        COMMIT
    } state_t;

    state_t                         state;
    logic                           issue;
    logic                           outstanding;
    logic [rnn_pkg::TOKEN_WIDTH-1:0] token_q;
    logic [EW-1:0]                  emb_cnt;
    logic [LW-1:0]                  hid_cnt;
    logic [LW-1:0]                  neuron_cnt;
    logic [AW-1:0]                  fetch_address;
    logic                           term_valid;
    rnn_pkg::fixed_t                term_operand;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= IDLE;
            issue       <= 1'b0;
            outstanding <= 1'b0;
            done        <= 1'b0;
            emb_cnt     <= '0;
            hid_cnt     <= '0;
            neuron_cnt  <= '0;
        end
        else
        begin
            issue <= 1'b0;
            done  <= (state == COMMIT);
            if (issue)
                outstanding <= 1'b1;
            else if (fetch_rsp.valid)
                outstanding <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (execute)
                    begin
                        token_q    <= token;
                        emb_cnt    <= '0;
                        hid_cnt    <= '0;
                        neuron_cnt <= '0;
                        state      <= EMB;
                        issue      <= 1'b1;
                    end
                end
                EMB, IH_W:
                begin
                    if (fetch_rsp.valid)
                    begin
                        issue <= 1'b1;
                        if (emb_cnt == EMB_LAST)
                        begin
                            emb_cnt <= '0;
                            state   <= (state == EMB) ? HH_W : IH_B;
                        end
                        else
                            emb_cnt <= emb_cnt + 1'b1;
                    end
                end
                HH_W:
                begin
                    if (fetch_rsp.valid)
                    begin
                        issue <= 1'b1;
                        if (hid_cnt == HID_LAST)
                        begin
                            hid_cnt <= '0;
                            state   <= HH_B;
                        end
                        else
                            hid_cnt <= hid_cnt + 1'b1;
                    end
                end
                HH_B:
                begin
                    if (fetch_rsp.valid)
                    begin
                        issue <= 1'b1;
                        state <= IH_W;
                    end
                end
                IH_B:
                begin
                    if (fetch_rsp.valid)
                        state <= SUM_WAIT;
                end
                SUM_WAIT:
                begin
                    if (mac_result.valid)
                    begin
                        if (neuron_cnt == HID_LAST)
                            state <= COMMIT;
                        else
                        begin
                            neuron_cnt <= neuron_cnt + 1'b1;
                            state      <= HH_W;
                            issue      <= 1'b1;
                        end
                    end
                end
                default:
                    state <= IDLE;  // COMMIT lasts one cycle
            endcase
        end
    end

    // Address of the word the current state wants next
    always_comb
    begin
        case (state)
            EMB:     fetch_address = AW'(token_q) * E_STEP + AW'(emb_cnt);
            HH_W:    fetch_address = HH_W_BASE + AW'(neuron_cnt) * L_STEP + AW'(hid_cnt);
            HH_B:    fetch_address = HH_B_BASE + AW'(neuron_cnt);
            IH_W:    fetch_address = IH_W_BASE + AW'(neuron_cnt) * E_STEP + AW'(emb_cnt);
            IH_B:    fetch_address = IH_B_BASE + AW'(neuron_cnt);
            default: fetch_address = '0;
        endcase
    end

    // Biases are multiplied by one so they share the product path
    always_comb
    begin
        term_valid   = 1'b1;
        term_operand = FIXED_ONE;
        case (state)
            HH_W:       term_operand = hidden_operand;
            IH_W:       term_operand = emb_operand;
            HH_B, IH_B: term_operand = FIXED_ONE;
            default:    term_valid = 1'b0;
        endcase
    end

    assign fetch_req = '{valid: issue, address: fetch_address};

    assign mac_term = '{valid:   fetch_rsp.valid && term_valid,
                        first:   (state == HH_W) && (hid_cnt == '0),
                        last:    (state == IH_B),
                        weight:  fetch_rsp.data,
                        operand: term_operand};

    assign emb_write         = fetch_rsp.valid && (state == EMB);
    assign emb_index         = emb_cnt;
    assign emb_read_index    = emb_cnt;
    assign hidden_read_index = hid_cnt;
    assign neuron_write      = mac_result.valid && (state == SUM_WAIT);
    assign neuron_index      = neuron_cnt;
    assign neuron_sum        = mac_result.sum;
    assign commit            = (state == COMMIT);

    single_outstanding_fetch: assert property (@(posedge clk) disable iff (reset)
        fetch_req.valid |-> !outstanding);

endmodule

`default_nettype wire

// File: design/rnn_cell_top.sv
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_top #(
    parameter int VOCAB_SIZE     = 76,
    parameter int EMBEDDING_SIZE = 4,
    parameter int LINEAR_SIZE    = 8,
    parameter int FRAC_BITS      = 8
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             execute,
    input  wire logic [rnn_pkg::TOKEN_WIDTH-1:0]  token,
    output rnn_pkg::mem_req_t                     mem_req,
    input  rnn_pkg::mem_rsp_t                     mem_rsp,
    input  wire logic [$clog2(LINEAR_SIZE)-1:0]   hidden_index,
    output rnn_pkg::fixed_t                       hidden_value,
    output logic                                  done
);

    rnn_pkg::mem_req_t    fetch_req;
    rnn_pkg::mem_rsp_t    fetch_rsp;
    rnn_pkg::mac_term_t   mac_term;
    rnn_pkg::mac_result_t mac_result;

    logic                              emb_write;
    logic [$clog2(EMBEDDING_SIZE)-1:0] emb_index;
    logic [$clog2(EMBEDDING_SIZE)-1:0] emb_read_index;
    logic                              neuron_write;
    logic [$clog2(LINEAR_SIZE)-1:0]    neuron_index;
    logic [$clog2(LINEAR_SIZE)-1:0]    hidden_read_index;
    rnn_pkg::fixed_t                   neuron_sum;
    rnn_pkg::fixed_t                   hidden_operand;
    rnn_pkg::fixed_t                   emb_operand;
    logic                              commit;

    step_sequencer #(
        .VOCAB_SIZE     (VOCAB_SIZE),
        .EMBEDDING_SIZE (EMBEDDING_SIZE),
        .LINEAR_SIZE    (LINEAR_SIZE),
        .FRAC_BITS      (FRAC_BITS)
    ) sequencer_i (
        .clk               (clk),
        .reset             (reset),
        .execute           (execute),
        .token             (token),
        .fetch_req         (fetch_req),
        .fetch_rsp         (fetch_rsp),
        .mac_term          (mac_term),
        .mac_result        (mac_result),
        .emb_write         (emb_write),
        .emb_index         (emb_index),
        .neuron_write      (neuron_write),
        .neuron_index      (neuron_index),
        .neuron_sum        (neuron_sum),
        .commit            (commit),
        .hidden_read_index (hidden_read_index),
        .emb_read_index    (emb_read_index),
        .hidden_operand    (hidden_operand),
        .emb_operand       (emb_operand),
        .done              (done)
    );

    weight_fetch fetch_i (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    neuron_mac #(
        .FRAC_BITS (FRAC_BITS)
    ) mac_i (
        .clk        (clk),
        .reset      (reset),
        .mac_term   (mac_term),
        .mac_result (mac_result)
    );

    hidden_state_bank #(
        .EMBEDDING_SIZE (EMBEDDING_SIZE),
        .LINEAR_SIZE    (LINEAR_SIZE)
    ) bank_i (
        .clk               (clk),
        .reset             (reset),
        .emb_write         (emb_write),
        .emb_index         (emb_index),
        .emb_data          (fetch_rsp.data),
        .neuron_write      (neuron_write),
        .neuron_index      (neuron_index),
        .neuron_sum        (neuron_sum),
        .commit            (commit),
        .hidden_read_index (hidden_read_index),
        .emb_read_index    (emb_read_index),
        .hidden_index      (hidden_index),
        .hidden_operand    (hidden_operand),
        .emb_operand       (emb_operand),
        .hidden_value      (hidden_value)
    );

endmodule

`default_nettype wire

// File: verification/rnn_model.svh
`ifndef RNN_MODEL_SVH
`define RNN_MODEL_SVH

// Weight memory regions, each right after the previous one
localparam int EMB_TABLE_BASE = 0;
localparam int IH_WEIGHT_BASE = EMB_TABLE_BASE + VOCAB_SIZE * EMBEDDING_SIZE;
localparam int HH_WEIGHT_BASE = IH_WEIGHT_BASE + LINEAR_SIZE * EMBEDDING_SIZE;
localparam int IH_BIAS_BASE   = HH_WEIGHT_BASE + LINEAR_SIZE * LINEAR_SIZE;
localparam int HH_BIAS_BASE   = IH_BIAS_BASE + LINEAR_SIZE;
localparam int MEM_WORDS      = HH_BIAS_BASE + LINEAR_SIZE;

rnn_pkg::fixed_t weight_mem [MEM_WORDS];
rnn_pkg::fixed_t model_prev [LINEAR_SIZE];  // Layer committed by the last finished step
int              expected_addresses [$];

// Q8.8 product, arithmetic shift then keep the low 16 bits
function automatic rnn_pkg::fixed_t scaled_product(input rnn_pkg::fixed_t weight,
                                                   input rnn_pkg::fixed_t operand);
    int product;
    product = int'(weight) * int'(operand);
    return rnn_pkg::fixed_t'(product >>> FRAC_BITS);
endfunction

function automatic void queue_step_addresses(input int step_token);
    for (int e = 0; e < EMBEDDING_SIZE; e++)
        expected_addresses.push_back(EMB_TABLE_BASE + step_token * EMBEDDING_SIZE + e);
    for (int j = 0; j < LINEAR_SIZE; j++)
    begin
        for (int k = 0; k < LINEAR_SIZE; k++)
            expected_addresses.push_back(HH_WEIGHT_BASE + j * LINEAR_SIZE + k);
        expected_addresses.push_back(HH_BIAS_BASE + j);
        for (int e = 0; e < EMBEDDING_SIZE; e++)
            expected_addresses.push_back(IH_WEIGHT_BASE + j * EMBEDDING_SIZE + e);
        expected_addresses.push_back(IH_BIAS_BASE + j);
    end
endfunction

function automatic void advance_model(input int step_token);
    rnn_pkg::fixed_t embedding  [EMBEDDING_SIZE];
    rnn_pkg::fixed_t next_layer [LINEAR_SIZE];
    rnn_pkg::fixed_t sum;
    for (int e = 0; e < EMBEDDING_SIZE; e++)
        embedding[e] = weight_mem[EMB_TABLE_BASE + step_token * EMBEDDING_SIZE + e];
    for (int j = 0; j < LINEAR_SIZE; j++)
    begin
        sum = '0;
        for (int k = 0; k < LINEAR_SIZE; k++)
            sum = sum + scaled_product(weight_mem[HH_WEIGHT_BASE + j * LINEAR_SIZE + k],
                                       model_prev[k]);
        sum = sum + weight_mem[HH_BIAS_BASE + j];  // Bias times one is the bias
        for (int e = 0; e < EMBEDDING_SIZE; e++)
            sum = sum + scaled_product(weight_mem[IH_WEIGHT_BASE + j * EMBEDDING_SIZE + e],
                                       embedding[e]);
        sum = sum + weight_mem[IH_BIAS_BASE + j];
        next_layer[j] = sum;
    end
    model_prev = next_layer;
endfunction

function automatic void clear_model();
    for (int i = 0; i < LINEAR_SIZE; i++)
        model_prev[i] = '0;
    expected_addresses.delete();
endfunction

`endif

// File: verification/tb_rnn_cell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rnn_cell;

    localparam int VOCAB_SIZE     = 76;
    localparam int EMBEDDING_SIZE = 4;
    localparam int LINEAR_SIZE    = 8;
    localparam int FRAC_BITS      = 8;
    localparam int TOKEN_BITS     = rnn_pkg::TOKEN_WIDTH;
    localparam int INDEX_BITS     = $clog2(LINEAR_SIZE);
    localparam int MAX_LATENCY    = 4;
    localparam int RANDOM_STEPS   = 12;
    localparam int TOTAL_STEPS    = RANDOM_STEPS + 4;  // Plus reset, overlap, abort, restart
    localparam int REQS_PER_STEP  = EMBEDDING_SIZE
                                    + LINEAR_SIZE * (LINEAR_SIZE + EMBEDDING_SIZE + 2);
    localparam int LATENCY_SLOTS  = TOTAL_STEPS * REQS_PER_STEP;
    localparam int WATCHDOG_NS    = TOTAL_STEPS * REQS_PER_STEP * (MAX_LATENCY + 6) * 10;

    logic                           clk;
    logic                           reset;
    logic                           execute;
    logic [TOKEN_BITS-1:0]          token;
    rnn_pkg::mem_req_t              mem_req;
    rnn_pkg::mem_rsp_t              mem_rsp = '0;
    logic [INDEX_BITS-1:0]          hidden_index;
    rnn_pkg::fixed_t                hidden_value;
    logic                           done;

    int                             seed;
    int                             latencies [LATENCY_SLOTS];
    logic [TOKEN_BITS-1:0]          step_tokens [TOTAL_STEPS];
    int                             total_requests = 0;
    int                             countdown = 0;
    logic [rnn_pkg::ADDR_WIDTH-1:0] rsp_address = '0;
    int                             step_first_request;
    string                          current_test;

    `include "rnn_model.svh"

    rnn_cell_top #(
        .VOCAB_SIZE     (VOCAB_SIZE),
        .EMBEDDING_SIZE (EMBEDDING_SIZE),
        .LINEAR_SIZE    (LINEAR_SIZE),
        .FRAC_BITS      (FRAC_BITS)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .execute      (execute),
        .token        (token),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .hidden_index (hidden_index),
        .hidden_value (hidden_value),
        .done         (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string test_name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("error: %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic accept_request(input logic [rnn_pkg::ADDR_WIDTH-1:0] address);
        if (expected_addresses.size() == 0)
            stop_with_error("the cell issued a memory read beyond the end of its step");
        else
        begin
            check($sformatf("%s address", current_test), expected_addresses.pop_front(),
                  int'(address));
            rsp_address    = address;
            countdown      = latencies[total_requests % LATENCY_SLOTS];
            total_requests = total_requests + 1;
        end
    endtask

    // Weight memory, one read at a time with a random latency
    always @(posedge clk)
    begin
        if (reset)
        begin
            mem_rsp   <= '0;
            countdown = 0;
        end
        else
        begin
            mem_rsp.valid <= 1'b0;
            if (countdown > 0)
            begin
                countdown = countdown - 1;
                if (countdown == 0)
                    mem_rsp <= '{valid: 1'b1, data: weight_mem[rsp_address]};
            end
            if (mem_req.valid)
                accept_request(mem_req.address);
        end
    end

    task automatic read_layer(input string test_name);
        for (int i = 0; i < LINEAR_SIZE; i++)
        begin
            @(posedge clk);
            hidden_index <= INDEX_BITS'(i);
            @(negedge clk);
            check($sformatf("%s hidden_value[%0d]", test_name, i), int'(model_prev[i]),
                  int'(hidden_value));
        end
    endtask

    task automatic start_step(input string test_name, input int step_token);
        current_test = test_name;
        queue_step_addresses(step_token);
        step_first_request = total_requests;
        @(posedge clk);
        execute <= 1'b1;
        token   <= TOKEN_BITS'(step_token);
        @(posedge clk);
        execute <= 1'b0;
    endtask

    task automatic finish_step(input int step_token);
        @(negedge clk);
        while (!done)
            @(negedge clk);
        advance_model(step_token);
        // New layer must already show in the done cycle
        check($sformatf("%s done cycle value", current_test), int'(model_prev[hidden_index]),
              int'(hidden_value));
        check($sformatf("%s request count", current_test), REQS_PER_STEP,
              total_requests - step_first_request);
        read_layer(current_test);
    endtask

    initial
    begin
        seed         = 32'h0c14f987;
        reset        = 1'b1;
        execute      = 1'b0;
        token        = '0;
        hidden_index = '0;
        for (int a = 0; a < MEM_WORDS; a++)
            weight_mem[a] = rnn_pkg::fixed_t'($random(seed) % 512);  // Within +-2.0
        for (int i = 0; i < LATENCY_SLOTS; i++)
            latencies[i] = 1 + int'($unsigned($random(seed)) % MAX_LATENCY);
        for (int i = 0; i < TOTAL_STEPS; i++)
            step_tokens[i] = TOKEN_BITS'($unsigned($random(seed)) % VOCAB_SIZE);
        clear_model();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start_step("step from reset", step_tokens[0]);
        finish_step(step_tokens[0]);

        for (int s = 1; s <= RANDOM_STEPS; s++)
        begin
            start_step($sformatf("recurrent step %0d", s), step_tokens[s]);
            finish_step(step_tokens[s]);
        end

        // A second pulse while busy must be ignored
        start_step("execute during step", step_tokens[13]);
        repeat (40) @(posedge clk);
        execute <= 1'b1;
        token   <= step_tokens[14];
        @(posedge clk);
        execute <= 1'b0;
        finish_step(step_tokens[13]);

        start_step("reset mid-step", step_tokens[14]);
        repeat (300) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        clear_model();
        read_layer("reset mid-step");

        start_step("step after reset", step_tokens[15]);
        finish_step(step_tokens[15]);

        $display("Simulation passed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the cell did not finish all steps within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
common/rnn_pkg.sv
design/weight_fetch.sv
design/neuron_mac.sv
design/hidden_state_bank.sv
design/step_sequencer/step_sequencer.sv
design/rnn_cell_top.sv
verification/tb_rnn_cell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, the exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/1ps -f list.f \
        --top-module tb_rnn_cell -o tb_rnn_cell \
    && ./obj_dir/tb_rnn_cell \
    || { echo "run_sim: build or simulation error"; exit 1; }
